// ==== verilog/psg_pkg.sv ====
package psg_pkg;

  localparam int NUM_CHANNELS = 3;
  localparam int PSG_DIV      = 25;  // 50 MHz / 25 = 2 MHz PSG tick
  localparam int PRESC_W      = $clog2(PSG_DIV);
  localparam int PERIOD_W     = 12;
  localparam int VOL_W        = 4;
  localparam int LEVEL_W      = 16;

  // Two ways of reading the same 16-bit register data word
  typedef struct packed {
    logic [3:0]          unused;
    logic [PERIOD_W-1:0] period;
  } tone_view_s;

  typedef struct packed {
    logic [10:0]      unused;
    logic             enable;
    logic [VOL_W-1:0] volume;
  } ctrl_view_s;

  typedef union packed {
    tone_view_s tone;
    ctrl_view_s ctrl;
  } psg_data_u;

  typedef struct packed {
    logic       ctrl_sel;  // Set selects the ctrl view
    logic [1:0] chan;
  } psg_addr_s;

  typedef struct packed {
    psg_addr_s addr;
    psg_data_u data;
  } psg_wr_s;

  typedef struct packed {
    logic [PERIOD_W-1:0] period;
    logic [VOL_W-1:0]    volume;
    logic                enable;
    logic                restart;  // One cycle, on period write
  } chan_cfg_s;

  // Roughly 3 dB per step, 3 x 10880 stays under 32767
  localparam logic [LEVEL_W-1:0] vol_table [16] = '{
    16'd0,    16'd86,   16'd122,  16'd173,
    16'd244,  16'd344,  16'd486,  16'd687,
    16'd970,  16'd1370, 16'd1935, 16'd2733,
    16'd3861, 16'd5453, 16'd7703, 16'd10880
  };

endpackage

// ==== verilog/dac_pkg.sv ====
package dac_pkg;

  // PCM sample format
  localparam int SAMPLE_W = 16;
  typedef logic signed [SAMPLE_W-1:0] pcm_t;

  // Modulator step rate, sys_clk / 4
  localparam int DAC_CE_DIV = 4;
  localparam int CE_CNT_W   = $clog2(DAC_CE_DIV);

  // Integrator width, 16x headroom over full scale
  localparam int ACC_W = 20;

  // Feedback amplitudes in offset binary terms
  localparam int FB_FULL = 2 ** SAMPLE_W;
  localparam int FB_HALF = 2 ** (SAMPLE_W - 1);

endpackage

// ==== verilog/psg_reg_port.sv ====
`timescale 1ns/1ns

module psg_reg_port (
  input  logic                                          sys_clk,
  input  logic                                          i_rst,
  input  psg_pkg::psg_wr_s                              i_wr,
  input  logic                                          i_req,
  output logic                                          o_ack,
  output psg_pkg::chan_cfg_s [psg_pkg::NUM_CHANNELS-1:0] o_cfg
);
  import psg_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_APPLY,
    ST_HOLD,
    ST_RELEASE
  } state_e;

  state_e state;
  logic   req_q;  // i_req after one register stage
  logic   apply;

  // Four-phase handshake
  // ack rises 2 cycles after req is sampled high, falls 2 cycles after it is sampled low
  always_ff @(posedge sys_clk) begin
    if (i_rst) begin
      req_q <= 1'b0;
      state <= ST_IDLE;
      o_ack <= 1'b0;
    end else begin
      req_q <= i_req;
      case (state)
        ST_IDLE: begin
          if (req_q) state <= ST_APPLY;  // Only reached with ack low
        end
        ST_APPLY: begin
          state <= ST_HOLD;
          o_ack <= 1'b1;
        end
        ST_HOLD: begin
          if (!req_q) state <= ST_RELEASE;
        end
        ST_RELEASE: begin
          state <= ST_IDLE;
          o_ack <= 1'b0;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  assign apply = (state == ST_APPLY);

  // Write decode, lands on the same edge as the ack rise
  always_ff @(posedge sys_clk) begin
    if (i_rst) begin
      o_cfg <= '0;
    end else begin
      for (int k = 0; k < NUM_CHANNELS; k++) begin
        o_cfg[k].restart <= 1'b0;
        if (apply && i_wr.addr.chan == k) begin
          if (i_wr.addr.ctrl_sel) begin
            o_cfg[k].enable <= i_wr.data.ctrl.enable;
            o_cfg[k].volume <= i_wr.data.ctrl.volume;
          end else begin
            o_cfg[k].period  <= i_wr.data.tone.period;
            o_cfg[k].restart <= 1'b1;  // Resync the divider
          end
        end
      end
    end
  end

endmodule

// ==== verilog/tone_channel.sv ====
`timescale 1ns/1ns

module tone_channel (
  input  logic                        sys_clk,
  input  logic                        i_rst,
  input  psg_pkg::chan_cfg_s          i_cfg,
  output logic [psg_pkg::LEVEL_W-1:0] o_level
);
  import psg_pkg::*;

  logic [PRESC_W-1:0]  presc;       // sys_clk to PSG tick
  logic [PERIOD_W-1:0] period_cnt;  // PSG ticks within a half wave
  logic                tone;
  logic                psg_tick;

  assign psg_tick = (presc == PRESC_W'(PSG_DIV - 1));

  // Square wave state
  // One toggle every period x PSG_DIV cycles
  always_ff @(posedge sys_clk) begin
    if (i_rst || i_cfg.restart) begin
      presc      <= '0;
      period_cnt <= '0;
      tone       <= 1'b1;  // Starts high
    end else begin
      if (psg_tick) begin
        presc <= '0;
      end else begin
        presc <= presc + 1'b1;
      end

      if (i_cfg.period == '0) begin
        // Period 0 holds the output high
        period_cnt <= '0;
        tone       <= 1'b1;
      end else if (psg_tick) begin
        if (period_cnt == i_cfg.period - 1'b1) begin
          period_cnt <= '0;
          tone       <= ~tone;
        end else begin
          period_cnt <= period_cnt + 1'b1;
        end
      end
    end
  end

  // Volume lookup, one cycle behind the tone state
  always_ff @(posedge sys_clk) begin
    if (i_rst) begin
      o_level <= '0;
    end else if (i_cfg.enable && tone) begin
      o_level <= vol_table[i_cfg.volume];
    end else begin
      o_level <= '0;
    end
  end

endmodule

// ==== verilog/channel_mixer.sv ====
`timescale 1ns/1ns

module channel_mixer (
  input  logic                                                 sys_clk,
  input  logic                                                 i_rst,
  input  logic [psg_pkg::NUM_CHANNELS-1:0][psg_pkg::LEVEL_W-1:0] i_levels,
  output dac_pkg::pcm_t                                        o_pcm
);
  import psg_pkg::*;
  import dac_pkg::*;

  logic [LEVEL_W:0]   pair_sum;   // First adder stage
  logic [LEVEL_W+1:0] total_sum;  // Second adder stage

  assign pair_sum  = i_levels[0] + i_levels[1];
  assign total_sum = pair_sum + i_levels[2];

  // Max is 3 x vol_table[15], always positive in 16 bits
  always_ff @(posedge sys_clk) begin
    if (i_rst) begin
      o_pcm <= '0;
    end else begin
      o_pcm <= pcm_t'(total_sum[SAMPLE_W-1:0]);
    end
  end

endmodule

// ==== verilog/sigma_delta_dac.sv ====
`timescale 1ns/1ns

module sigma_delta_dac (
  input  logic          sys_clk,
  input  logic          i_rst,
  input  dac_pkg::pcm_t i_pcm,
  output logic          o_audio,
  output logic          o_acc1_overflow,
  output logic          o_acc2_overflow
);
  import dac_pkg::*;

  logic [CE_CNT_W-1:0]   ce_cnt;
  logic                  step;
  logic [SAMPLE_W-1:0]   pcm_offset;  // Offset binary sample
  logic signed [ACC_W:0] in_ext;
  logic signed [ACC_W:0] fb_full;     // Stage 1 feedback, 0 or full scale
  logic signed [ACC_W:0] fb_half;     // Stage 2 feedback, centred
  logic signed [ACC_W:0] sum1;
  logic signed [ACC_W:0] sum2;
  logic signed [ACC_W-1:0] acc1;
  logic signed [ACC_W-1:0] acc2;
  logic signed [ACC_W-1:0] acc1_next;

  // Step enable, one in DAC_CE_DIV cycles
  always_ff @(posedge sys_clk) begin
    if (i_rst) begin
      ce_cnt <= '0;
    end else if (step) begin
      ce_cnt <= CE_CNT_W'(DAC_CE_DIV - 1);
    end else begin
      ce_cnt <= ce_cnt - 1'b1;
    end
  end

  assign step = (ce_cnt == '0);

  assign pcm_offset = {~i_pcm[SAMPLE_W-1], i_pcm[SAMPLE_W-2:0]};
  assign in_ext     = (ACC_W + 1)'(pcm_offset);
  assign fb_full    = o_audio ? (ACC_W + 1)'(FB_FULL) : '0;
  assign fb_half    = o_audio ? (ACC_W + 1)'(FB_HALF) : -(ACC_W + 1)'(FB_HALF);

  // Two integrators, the second fed from the updated first
  assign sum1      = acc1 + in_ext - fb_full;
  assign acc1_next = sum1[ACC_W-1:0];
  assign sum2      = acc2 + acc1_next - fb_half;

  always_ff @(posedge sys_clk) begin
    if (i_rst) begin
      acc1            <= '0;
      acc2            <= '0;
      o_audio         <= 1'b0;
      o_acc1_overflow <= 1'b0;
      o_acc2_overflow <= 1'b0;
    end else if (step) begin
      acc1    <= acc1_next;
      acc2    <= sum2[ACC_W-1:0];
      o_audio <= ~sum2[ACC_W-1];  // One when stage 2 is non-negative

      // Sticky, set once a sum leaves the ACC_W range
      if (sum1[ACC_W] != sum1[ACC_W-1]) o_acc1_overflow <= 1'b1;
      if (sum2[ACC_W] != sum2[ACC_W-1]) o_acc2_overflow <= 1'b1;
    end
  end

endmodule

// ==== verilog/psg_audio_top.sv ====
`timescale 1ns/1ns

module psg_audio_top (
  input  logic             sys_clk,
  input  logic             i_rst,
  input  psg_pkg::psg_wr_s i_wr,
  input  logic             i_req,
  output logic             o_ack,
  output dac_pkg::pcm_t    o_pcm,
  output logic             o_audio,
  output logic             o_acc1_overflow,
  output logic             o_acc2_overflow
);
  import psg_pkg::*;

  chan_cfg_s [NUM_CHANNELS-1:0]         cfg;
  logic [NUM_CHANNELS-1:0][LEVEL_W-1:0] levels;

  psg_reg_port u_reg_port (
    .sys_clk (sys_clk),
    .i_rst   (i_rst),
    .i_wr    (i_wr),
    .i_req   (i_req),
    .o_ack   (o_ack),
    .o_cfg   (cfg)
  );

  // One tone divider per channel
  for (genvar k = 0; k < NUM_CHANNELS; k++) begin : g_chan
    tone_channel u_tone (
      .sys_clk (sys_clk),
      .i_rst   (i_rst),
      .i_cfg   (cfg[k]),
      .o_level (levels[k])
    );
  end

  channel_mixer u_mixer (
    .sys_clk  (sys_clk),
    .i_rst    (i_rst),
    .i_levels (levels),
    .o_pcm    (o_pcm)
  );

  // PCM also goes out for observation
  sigma_delta_dac u_dac (
    .sys_clk         (sys_clk),
    .i_rst           (i_rst),
    .i_pcm           (o_pcm),
    .o_audio         (o_audio),
    .o_acc1_overflow (o_acc1_overflow),
    .o_acc2_overflow (o_acc2_overflow)
  );

endmodule

// ==== tb/psg_audio_asserts.sv ====
`timescale 1ns/1ns

module psg_audio_asserts (
  input logic                             sys_clk,
  input logic                             i_rst,
  input logic                             i_req,
  input logic                             i_ack,
  input dac_pkg::pcm_t                    i_pcm,
  input logic signed [dac_pkg::ACC_W-1:0] i_acc1,
  input logic signed [dac_pkg::ACC_W-1:0] i_acc2
);
  import psg_pkg::*;

  int assert_errors = 0;  // Read by the testbench at the end

  // Ack follows req, never leads it
  a_ack_rise: assert property (@(posedge sys_clk) disable iff (i_rst)
    $rose(i_ack) |-> $past(i_req))
    else begin
      $error("o_ack rose while i_req was low");
      assert_errors++;
    end

  a_ack_fall: assert property (@(posedge sys_clk) disable iff (i_rst)
    $fell(i_ack) |-> !$past(i_req))
    else begin
      $error("o_ack fell while i_req was high");
      assert_errors++;
    end

  a_pcm_range: assert property (@(posedge sys_clk) disable iff (i_rst)
    i_pcm >= 0 && int'(i_pcm) <= 3 * int'(vol_table[15]))
    else begin
      $error("o_pcm outside the three channel range");
      assert_errors++;
    end

  // Integrators stay known once out of reset
  a_acc_known: assert property (@(posedge sys_clk) disable iff (i_rst)
    !$isunknown({i_acc1, i_acc2}))
    else begin
      $error("DAC accumulator went unknown");
      assert_errors++;
    end

endmodule

bind psg_audio_top psg_audio_asserts u_asserts (
  .sys_clk (sys_clk),
  .i_rst   (i_rst),
  .i_req   (i_req),
  .i_ack   (o_ack),
  .i_pcm   (o_pcm),
  .i_acc1  (u_dac.acc1),
  .i_acc2  (u_dac.acc2)
);

// ==== tb/psg_audio_checker.sv ====
`timescale 1ns/1ns

module psg_audio_checker (
  input logic             sys_clk,
  input logic             i_rst,
  input psg_pkg::psg_wr_s i_wr,
  input logic             i_req,
  input logic             i_ack,
  input dac_pkg::pcm_t    i_pcm,
  input logic             i_audio,
  input logic             i_acc1_overflow,
  input logic             i_acc2_overflow
);
  import psg_pkg::*;
  import dac_pkg::*;

  chan_cfg_s [NUM_CHANNELS-1:0] shadow;  // Host view of the channel registers
  logic  req_prev;
  logic  ack_prev;
  int    req_age;                // Edges since i_req settled
  int    age_prev;
  int    exp_pcm;
  logic  compare_en  = 1'b0;     // Set by the testbench while all tones are held
  int    test_errors = 0;
  int    pass_count  = 0;
  int    fail_count  = 0;
  string test_name   = "";

  // Table levels of the enabled channels whose tone is high
  function automatic int expected_pcm(input chan_cfg_s [NUM_CHANNELS-1:0] cfg,
                                      input logic [NUM_CHANNELS-1:0] tone_hi);
    int sum;
    sum = 0;
    for (int k = 0; k < NUM_CHANNELS; k++) begin
      if (cfg[k].enable && tone_hi[k]) sum += int'(vol_table[cfg[k].volume]);
    end
    return sum;
  endfunction

  function automatic logic [NUM_CHANNELS-1:0] held_tones(
    input chan_cfg_s [NUM_CHANNELS-1:0] cfg);
    logic [NUM_CHANNELS-1:0] held;
    for (int k = 0; k < NUM_CHANNELS; k++) held[k] = (cfg[k].period == '0);
    return held;
  endfunction

  task automatic mismatch(input string sig, input int exp_val, input int got_val);
    $display("MISMATCH %s expected %0h got %0h (%s)", sig, exp_val, got_val, test_name);
    test_errors++;
  endtask

  task automatic report_error(input string what);
    $display("ERROR in %s: %s", test_name, what);
    test_errors++;
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    if (test_errors == 0) begin
      pass_count++;
      $display("PASS %s", test_name);
    end else begin
      fail_count++;
      $display("FAIL %s with %0d errors", test_name, test_errors);
    end
  endtask

  task automatic abort_test(input string why);
    report_error(why);
    end_test();
  endtask

  task automatic check_idle();
    if (i_ack !== 1'b0) mismatch("o_ack", 0, i_ack);
    if (i_audio !== 1'b0) mismatch("o_audio", 0, i_audio);
    if (i_acc1_overflow !== 1'b0) mismatch("o_acc1_overflow", 0, i_acc1_overflow);
    if (i_acc2_overflow !== 1'b0) mismatch("o_acc2_overflow", 0, i_acc2_overflow);
    if (i_pcm !== '0) mismatch("o_pcm", 0, int'(i_pcm));
  endtask

  // Square wave on o_pcm with full half waves from the restart
  task automatic check_tone(input int period);
    int   gap;
    int   hi;
    int   n;
    int   want;
    pcm_t prev;
    gap = period * PSG_DIV;
    hi  = expected_pcm(shadow, '1);
    if (i_pcm !== pcm_t'(hi)) mismatch("o_pcm", hi, int'(i_pcm));  // Starts high
    for (int t = 0; t < 7; t++) begin
      prev = i_pcm;
      n    = 0;
      while (i_pcm === prev && n <= 2 * gap) begin
        @(negedge sys_clk);
        n++;
      end
      if (i_pcm === prev) begin
        report_error("o_pcm stopped toggling");
        return;
      end
      want = (prev == pcm_t'(hi)) ? 0 : hi;
      if (n != gap) mismatch("o_pcm toggle spacing", gap, n);
      if (i_pcm !== pcm_t'(want)) mismatch("o_pcm", want, int'(i_pcm));
    end
  endtask

  // Ones on o_audio over 4096 modulator steps
  task automatic check_density();
    int   high_cycles;
    int   ones;
    int   exp_ones;
    pcm_t level;
    high_cycles = 0;
    level       = i_pcm;
    for (int n = 0; n < 4096 * DAC_CE_DIV; n++) begin
      @(negedge sys_clk);
      if (i_audio) high_cycles++;
      if (i_pcm !== level) begin
        report_error("o_pcm moved during the density window");
        return;
      end
    end
    ones     = (high_cycles + DAC_CE_DIV / 2) / DAC_CE_DIV;
    exp_ones = (int'(level) + 32768) / 16;
    if (ones < exp_ones - 4 || ones > exp_ones + 4) mismatch("o_audio ones", exp_ones, ones);
    if (i_acc1_overflow) report_error("first accumulator overflowed");
    if (i_acc2_overflow) report_error("second accumulator overflowed");
  endtask

  always @(posedge sys_clk) begin
    if (i_rst) begin
      shadow   = '0;
      req_prev = 1'b0;
      ack_prev = 1'b0;
      req_age  = 0;
      age_prev = 0;
    end else begin
      // Ack moves toward req 2 edges after req settled
      if (i_ack != ack_prev) begin
        if (i_ack != req_prev) begin
          report_error("o_ack changed against i_req");
        end else if (age_prev != 2) begin
          mismatch("o_ack latency", 2, age_prev);
        end
        if (i_ack && i_wr.addr.chan < NUM_CHANNELS) begin
          if (i_wr.addr.ctrl_sel) begin
            shadow[i_wr.addr.chan].enable = i_wr.data.ctrl.enable;
            shadow[i_wr.addr.chan].volume = i_wr.data.ctrl.volume;
          end else begin
            shadow[i_wr.addr.chan].period = i_wr.data.tone.period;
          end
        end
      end
      exp_pcm = expected_pcm(shadow, held_tones(shadow));
      if (compare_en && i_pcm !== pcm_t'(exp_pcm)) mismatch("o_pcm", exp_pcm, int'(i_pcm));
      req_age  = (i_req != req_prev) ? 0 : req_age + 1;
      age_prev = req_age;
      req_prev = i_req;
      ack_prev = i_ack;
    end
  end

endmodule

// ==== tb/psg_audio_tb.sv ====
`timescale 1ns/1ns

module psg_audio_tb;
  import psg_pkg::*;
  import dac_pkg::*;

  logic        sys_clk;
  logic        i_rst;
  psg_wr_s     i_wr;
  logic        i_req;
  logic        o_ack;
  pcm_t        o_pcm;
  logic        o_audio;
  logic        o_acc1_overflow;
  logic        o_acc2_overflow;
  logic [31:0] lcg_state;
  psg_data_u   rand_word;
  int          vols [NUM_CHANNELS];
  int          chan;
  int          sel;
  int          data;
  int          vol;
  int          period;

  psg_audio_top dut (.*);

  psg_audio_checker chk (
    .sys_clk         (sys_clk),
    .i_rst           (i_rst),
    .i_wr            (i_wr),
    .i_req           (i_req),
    .i_ack           (o_ack),
    .i_pcm           (o_pcm),
    .i_audio         (o_audio),
    .i_acc1_overflow (o_acc1_overflow),
    .i_acc2_overflow (o_acc2_overflow)
  );

  initial sys_clk = 1'b0;
  always #5 sys_clk = ~sys_clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic draw(input int range, output int value);
    lcg_state = lcg_next(lcg_state);
    value     = int'(lcg_state[31:16]) % range;  // Upper bits are the better ones
  endtask

  function automatic psg_data_u tone_word(input int period_val);
    psg_data_u d;
    d             = '0;
    d.tone.period = PERIOD_W'(period_val);
    return d;
  endfunction

  function automatic psg_data_u ctrl_word(input logic en, input int vol_val);
    psg_data_u d;
    d             = '0;
    d.ctrl.enable = en;
    d.ctrl.volume = VOL_W'(vol_val);
    return d;
  endfunction

  task automatic finish_run();
    $display("Tests passed: %0d, failed: %0d, assertion errors: %0d",
             chk.pass_count, chk.fail_count, dut.u_asserts.assert_errors);
    if (chk.fail_count == 0 && dut.u_asserts.assert_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  endtask

  task automatic wait_ack(input logic level);
    int n;
    n = 0;
    while (o_ack !== level && n < 20) begin  // Handshake needs 3 cycles each way
      @(negedge sys_clk);
      n++;
    end
    if (o_ack !== level) begin
      chk.abort_test($sformatf("timed out waiting for o_ack to go %0b", level));
      finish_run();
    end
  endtask

  task automatic write_reg(input logic ctrl_sel, input int chan_sel, input psg_data_u word);
    i_wr.addr.ctrl_sel = ctrl_sel;
    i_wr.addr.chan     = 2'(chan_sel);
    i_wr.data          = word;
    i_req              = 1'b1;
    wait_ack(1'b1);
    i_req = 1'b0;
    wait_ack(1'b0);
  endtask

  // Compare window for held tones, after the 3-cycle write latency
  task automatic hold_compare(input int cycles);
    repeat (4) @(negedge sys_clk);
    chk.compare_en = 1'b1;
    repeat (cycles) @(negedge sys_clk);
    chk.compare_en = 1'b0;
  endtask

  initial begin
    lcg_state = 32'h61aac534;
    i_rst     = 1'b1;
    i_req     = 1'b0;
    i_wr      = '0;
    repeat (4) @(negedge sys_clk);
    i_rst = 1'b0;

    chk.start_test("reset and silence");
    chk.check_idle();
    write_reg(1'b1, 0, ctrl_word(1'b1, 0));  // Enabled but silent
    hold_compare(64);
    chk.end_test();

    chk.start_test("handshake timing");
    for (int i = 0; i < 20; i++) begin
      draw(NUM_CHANNELS, chan);
      draw(2, sel);
      draw(65536, data);
      rand_word = data[15:0];
      write_reg(sel[0], chan, rand_word);
    end
    chk.end_test();

    chk.start_test("single tone");
    draw(NUM_CHANNELS, chan);
    draw(15, vol);
    draw(8, period);
    vol    = vol + 1;
    period = period + 1;
    for (int k = 0; k < NUM_CHANNELS; k++) write_reg(1'b1, k, ctrl_word(k == chan, vol));
    write_reg(1'b0, chan, tone_word(period));  // Restart, tone goes high
    chk.check_tone(period);
    chk.end_test();

    chk.start_test("held tones and mixing");
    for (int k = 0; k < NUM_CHANNELS; k++) begin
      draw(12, vols[k]);
      vols[k] = vols[k] + 1;  // Keeps the DAC input well inside full scale
      write_reg(1'b0, k, tone_word(0));
      write_reg(1'b1, k, ctrl_word(1'b1, vols[k]));
    end
    hold_compare(64);
    draw(NUM_CHANNELS, chan);
    write_reg(1'b1, chan, ctrl_word(1'b0, vols[chan]));  // Period stays 0
    hold_compare(64);
    chk.end_test();

    chk.start_test("DAC density");
    hold_compare(256);
    chk.check_density();
    for (int k = 0; k < NUM_CHANNELS; k++) write_reg(1'b1, k, ctrl_word(1'b0, 0));
    hold_compare(256);
    chk.check_density();
    chk.end_test();

    finish_run();
  end

endmodule

// ==== psg_audio.f ====
verilog/psg_pkg.sv
verilog/dac_pkg.sv
verilog/psg_reg_port.sv
verilog/tone_channel.sv
verilog/channel_mixer.sv
verilog/sigma_delta_dac.sv
verilog/psg_audio_top.sv
tb/psg_audio_asserts.sv
tb/psg_audio_checker.sv
tb/psg_audio_tb.sv

// ==== Bender.yml ====
package:
  name: psg_audio

sources:
  - files:
      - verilog/psg_pkg.sv
      - verilog/dac_pkg.sv
      - verilog/psg_reg_port.sv
      - verilog/tone_channel.sv
      - verilog/channel_mixer.sv
      - verilog/sigma_delta_dac.sv
      - verilog/psg_audio_top.sv
  - target: test
    files:
      - tb/psg_audio_asserts.sv
      - tb/psg_audio_checker.sv
      - tb/psg_audio_tb.sv
